// ==== logic/tape_params.svh ====
// Tape byte server widths for addresses, memory words and bytes
`ifndef TAPE_PARAMS_SVH
`define TAPE_PARAMS_SVH

// Byte address into the tape image
`define TAPE_ADDR_W 12

// Memory word, two tape bytes per entry
`define TAPE_WORD_W 16

// One tape byte as seen by the player
`define TAPE_BYTE_W 8

`endif

// ==== logic/tape_pkg.sv ====
// Tape byte server types for the play mode and the fetch command
`default_nettype none

package tape_pkg;

    // Player state, motor runs only in MODE_PLAYING
    typedef enum logic [1:0] {
        MODE_LOADING = 2'd0,
        MODE_PAUSED  = 2'd1,
        MODE_PLAYING = 2'd2
    } play_mode_e;

    // Position control to byte fetch
    typedef enum logic [1:0] {
        CMD_NONE       = 2'd0,
        CMD_FETCH_WORD = 2'd1,
        CMD_REUSE_WORD = 2'd2
    } fetch_cmd_e;

endpackage

`default_nettype wire

// ==== logic/tape_event_decode.sv ====
// Tape event decode, turns the request toggle and control marks into strobes
`timescale 1ns/1ps
`default_nettype none

module tape_event_decode (
    input  wire  clk_28,
    input  wire  reset,
    input  wire  i_download,
    input  wire  i_byte_req,
    input  wire  i_loop_start,
    input  wire  i_loop_next,
    input  wire  i_stop,
    input  wire  i_pause_btn,
    output logic o_loading,
    output logic o_req_evt,
    output logic o_loop_start_evt,
    output logic o_loop_next_evt,
    output logic o_stop_evt,
    output logic o_pause_evt
);

    // Delayed copies of the raw inputs
    logic req_d;
    logic loop_start_d;
    logic loop_next_d;
    logic stop_d;
    logic pause_d;

    always_ff @(posedge clk_28 or posedge reset) begin
        if (reset) begin
            o_loading        <= 1'b0;
            req_d            <= 1'b0;
            loop_start_d     <= 1'b0;
            loop_next_d      <= 1'b0;
            stop_d           <= 1'b0;
            pause_d          <= 1'b0;
            o_req_evt        <= 1'b0;
            o_loop_start_evt <= 1'b0;
            o_loop_next_evt  <= 1'b0;
            o_stop_evt       <= 1'b0;
            o_pause_evt      <= 1'b0;
        end else begin
            o_loading    <= i_download;
            req_d        <= i_byte_req;
            loop_start_d <= i_loop_start;
            loop_next_d  <= i_loop_next;
            stop_d       <= i_stop;
            pause_d      <= i_pause_btn;

            // Either toggle direction asks for a byte
            o_req_evt <= i_byte_req ^ req_d;

            // Marks and button act on rising edges only
            o_loop_start_evt <= i_loop_start & ~loop_start_d;
            o_loop_next_evt  <= i_loop_next & ~loop_next_d;
            o_stop_evt       <= i_stop & ~stop_d;
            o_pause_evt      <= i_pause_btn & ~pause_d;
        end
    end

    // Player keeps one request in flight, so toggles never come back to back
    a_req_single: assert property (
        @(posedge clk_28) disable iff (reset) o_req_evt |=> !o_req_evt
    ) else $error("tape_event_decode: request strobe high in two cycles");

endmodule

`default_nettype wire

// ==== logic/tape_position_ctrl.sv ====
// Tape position control that keeps the play, last and loop addresses and decides fetches
`timescale 1ns/1ps
`default_nettype none

`include "tape_params.svh"

module tape_position_ctrl (
    input  wire                     clk_28,
    input  wire                     reset,
    input  wire                     i_loading,
    input  wire                     i_dl_wr,
    input  wire [`TAPE_ADDR_W-1:0]  i_dl_addr,
    input  wire                     i_req_evt,
    input  wire                     i_loop_start_evt,
    input  wire                     i_loop_next_evt,
    input  wire                     i_stop_evt,
    input  wire                     i_pause_evt,
    input  wire                     i_delivered,
    output tape_pkg::fetch_cmd_e    o_cmd,
    output logic [`TAPE_ADDR_W-2:0] o_rd_word_addr,
    output logic                    o_lane_low,
    output logic                    o_motor
);

    import tape_pkg::*;

    logic [`TAPE_ADDR_W-1:0] play_addr;
    logic [`TAPE_ADDR_W-1:0] last_addr;
    logic [`TAPE_ADDR_W-1:0] loop_addr;
    logic [`TAPE_ADDR_W-1:0] end_addr;
    // Held word in the fetch stage no longer matches play_addr
    logic                    stale;
    play_mode_e              mode;

    // One past the last downloaded byte
    assign end_addr = last_addr + 1'b1;

    // ========================================================================
    // Address and mode update
    // ========================================================================
    always_ff @(posedge clk_28 or posedge reset) begin
        if (reset) begin
            play_addr <= '0;
            last_addr <= '0;
            loop_addr <= '0;
            stale     <= 1'b0;
            mode      <= MODE_PAUSED;
            o_cmd     <= CMD_NONE;
        end else begin
            o_cmd <= CMD_NONE;

            if (i_dl_wr) begin
                last_addr <= i_dl_addr;
            end

            if (i_loading) begin
                play_addr <= '0;
                loop_addr <= '0;
                stale     <= 1'b0;
                mode      <= MODE_LOADING;
            end else begin
                if (mode == MODE_LOADING) begin
                    mode <= MODE_PAUSED;
                end

                if (i_req_evt) begin
                    // Past the end of the image the player pauses and the request stays open
                    if (play_addr == end_addr) begin
                        mode <= MODE_PAUSED;
                    end else if (stale || !play_addr[0]) begin
                        o_cmd <= CMD_FETCH_WORD;
                    end else begin
                        o_cmd <= CMD_REUSE_WORD;
                    end
                end

                if (i_delivered) begin
                    play_addr <= play_addr + 1'b1;
                    stale     <= 1'b0;
                end

                if (i_stop_evt) begin
                    mode <= MODE_PAUSED;
                end

                if (i_loop_start_evt) begin
                    loop_addr <= play_addr;
                end

                // Overrides the increment of a delivery in the same cycle
                if (i_loop_next_evt) begin
                    play_addr <= loop_addr;
                    stale     <= 1'b1;
                end

                if (i_pause_evt) begin
                    if (mode == MODE_PLAYING) begin
                        mode <= MODE_PAUSED;
                    end else begin
                        mode <= MODE_PLAYING;
                    end
                end
            end
        end
    end

    assign o_rd_word_addr = play_addr[`TAPE_ADDR_W-1:1];
    assign o_lane_low     = play_addr[0];
    assign o_motor        = (mode == MODE_PLAYING);

    // No memory command is pending while a download runs
    a_no_cmd_loading: assert property (
        @(posedge clk_28) disable iff (reset) i_loading |-> o_cmd == CMD_NONE
    ) else $error("tape_position_ctrl: command issued during download");

endmodule

`default_nettype wire

// ==== logic/tape_word_ram.sv ====
// Tape word memory, byte writes from the download and registered word reads
`timescale 1ns/1ps
`default_nettype none

`include "tape_params.svh"

module tape_word_ram (
    input  wire                     clk_28,
    input  wire                     i_wr,
    input  wire [`TAPE_ADDR_W-1:0]  i_wr_addr,
    input  wire [`TAPE_BYTE_W-1:0]  i_wr_data,
    input  wire                     i_rd,
    input  wire [`TAPE_ADDR_W-2:0]  i_rd_addr,
    output logic [`TAPE_WORD_W-1:0] o_rd_data
);

    logic [`TAPE_WORD_W-1:0] mem [0:(2**(`TAPE_ADDR_W-1))-1];

    always_ff @(posedge clk_28) begin
        // Even bytes sit in the high half of the word
        if (i_wr) begin
            if (i_wr_addr[0]) begin
                mem[i_wr_addr[`TAPE_ADDR_W-1:1]][`TAPE_BYTE_W-1:0] <= i_wr_data;
            end else begin
                mem[i_wr_addr[`TAPE_ADDR_W-1:1]][`TAPE_WORD_W-1:`TAPE_BYTE_W] <= i_wr_data;
            end
        end
        if (i_rd) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/tape_byte_fetch.sv ====
// Tape byte fetch, sequences word reads and returns bytes with the ack toggle
`timescale 1ns/1ps
`default_nettype none

`include "tape_params.svh"

module tape_byte_fetch (
    input  wire                     clk_28,
    input  wire                     reset,
    input  tape_pkg::fetch_cmd_e    i_cmd,
    input  wire [`TAPE_ADDR_W-2:0]  i_rd_word_addr,
    input  wire                     i_lane_low,
    input  wire                     i_byte_req,
    input  wire                     i_dl_wr,
    input  wire [`TAPE_ADDR_W-1:0]  i_dl_addr,
    input  wire [`TAPE_BYTE_W-1:0]  i_dl_data,
    output logic [`TAPE_BYTE_W-1:0] o_byte_data,
    output logic                    o_byte_ack,
    output logic                    o_delivered
);

    import tape_pkg::*;

    logic                    rd_issue;
    // RAM output holds the requested word this cycle
    logic                    rd_return;
    logic [`TAPE_ADDR_W-2:0] rd_addr;
    logic                    lane_q;
    logic [`TAPE_WORD_W-1:0] ram_data;
    logic [`TAPE_WORD_W-1:0] held_word;
    logic [`TAPE_WORD_W-1:0] src_word;
    logic                    src_lane;
    logic [`TAPE_BYTE_W-1:0] sel_byte;
    logic                    serve;

    tape_word_ram u_ram (
        .clk_28    (clk_28),
        .i_wr      (i_dl_wr),
        .i_wr_addr (i_dl_addr),
        .i_wr_data (i_dl_data),
        .i_rd      (rd_issue),
        .i_rd_addr (rd_addr),
        .o_rd_data (ram_data)
    );

    // ========================================================================
    // Byte selection
    // ========================================================================
    // Fresh data from the RAM, otherwise the word kept from the last fetch
    always_comb begin
        src_word = rd_return ? ram_data : held_word;
        src_lane = rd_return ? lane_q : i_lane_low;
        if (src_lane) begin
            sel_byte = src_word[`TAPE_BYTE_W-1:0];
        end else begin
            sel_byte = src_word[`TAPE_WORD_W-1:`TAPE_BYTE_W];
        end
    end

    assign serve = rd_return || (i_cmd == CMD_REUSE_WORD);

    // ========================================================================
    // Read sequencing and handshake
    // ========================================================================
    always_ff @(posedge clk_28 or posedge reset) begin
        if (reset) begin
            rd_issue    <= 1'b0;
            rd_return   <= 1'b0;
            o_byte_ack  <= 1'b0;
            o_delivered <= 1'b0;
        end else begin
            rd_issue    <= (i_cmd == CMD_FETCH_WORD);
            rd_return   <= rd_issue;
            o_delivered <= serve;
            if (serve) begin
                o_byte_ack <= i_byte_req;
            end
        end
    end

    always_ff @(posedge clk_28) begin
        // Latch address and lane, control may move on before data returns
        if (i_cmd == CMD_FETCH_WORD) begin
            rd_addr <= i_rd_word_addr;
            lane_q  <= i_lane_low;
        end
        if (rd_return) begin
            held_word <= ram_data;
        end
        if (serve) begin
            o_byte_data <= sel_byte;
        end
    end

    // Control only commands once the previous byte has been delivered
    a_no_cmd_pending: assert property (
        @(posedge clk_28) disable iff (reset)
        (i_cmd != CMD_NONE) |-> !(rd_issue || rd_return)
    ) else $error("tape_byte_fetch: command arrived during a pending fetch");

endmodule

`default_nettype wire

// ==== logic/tape_buffer_top.sv ====
// Tape byte server top, joins event decode, position control and byte fetch
`timescale 1ns/1ps
`default_nettype none

`include "tape_params.svh"

module tape_buffer_top (
    input  wire                     clk_28,
    input  wire                     reset,
    input  wire                     i_download,
    input  wire                     i_dl_wr,
    input  wire [`TAPE_ADDR_W-1:0]  i_dl_addr,
    input  wire [`TAPE_BYTE_W-1:0]  i_dl_data,
    input  wire                     i_byte_req,
    input  wire                     i_loop_start,
    input  wire                     i_loop_next,
    input  wire                     i_stop,
    input  wire                     i_pause_btn,
    output logic                    o_byte_ack,
    output logic [`TAPE_BYTE_W-1:0] o_byte_data,
    output logic                    o_motor
);

    import tape_pkg::*;

    // ========================================================================
    // Stage interconnect
    // ========================================================================
    logic                    loading;
    logic                    req_evt;
    logic                    loop_start_evt;
    logic                    loop_next_evt;
    logic                    stop_evt;
    logic                    pause_evt;
    fetch_cmd_e              cmd;
    logic [`TAPE_ADDR_W-2:0] rd_word_addr;
    logic                    lane_low;
    logic                    delivered;

    tape_event_decode u_decode (
        .clk_28           (clk_28),
        .reset            (reset),
        .i_download       (i_download),
        .i_byte_req       (i_byte_req),
        .i_loop_start     (i_loop_start),
        .i_loop_next      (i_loop_next),
        .i_stop           (i_stop),
        .i_pause_btn      (i_pause_btn),
        .o_loading        (loading),
        .o_req_evt        (req_evt),
        .o_loop_start_evt (loop_start_evt),
        .o_loop_next_evt  (loop_next_evt),
        .o_stop_evt       (stop_evt),
        .o_pause_evt      (pause_evt)
    );

    tape_position_ctrl u_ctrl (
        .clk_28           (clk_28),
        .reset            (reset),
        .i_loading        (loading),
        .i_dl_wr          (i_dl_wr),
        .i_dl_addr        (i_dl_addr),
        .i_req_evt        (req_evt),
        .i_loop_start_evt (loop_start_evt),
        .i_loop_next_evt  (loop_next_evt),
        .i_stop_evt       (stop_evt),
        .i_pause_evt      (pause_evt),
        .i_delivered      (delivered),
        .o_cmd            (cmd),
        .o_rd_word_addr   (rd_word_addr),
        .o_lane_low       (lane_low),
        .o_motor          (o_motor)
    );

    // Download writes go straight to memory, no back-pressure
    tape_byte_fetch u_fetch (
        .clk_28         (clk_28),
        .reset          (reset),
        .i_cmd          (cmd),
        .i_rd_word_addr (rd_word_addr),
        .i_lane_low     (lane_low),
        .i_byte_req     (i_byte_req),
        .i_dl_wr        (i_dl_wr),
        .i_dl_addr      (i_dl_addr),
        .i_dl_data      (i_dl_data),
        .o_byte_data    (o_byte_data),
        .o_byte_ack     (o_byte_ack),
        .o_delivered    (delivered)
    );

endmodule

`default_nettype wire

// ==== verification/tape_buffer_tb.sv ====
// Tape byte server testbench, plays a random image through the top level and checks each byte
`timescale 1ns/1ps
`default_nettype none

`include "tape_params.svh"

module tape_buffer_tb;

    localparam int IMG_LEN         = 24;
    localparam int ACK_TIMEOUT     = 20;
    localparam int MOTOR_TIMEOUT   = 10;
    localparam int MARK_LOOP_START = 0;
    localparam int MARK_LOOP_NEXT  = 1;
    localparam int MARK_STOP       = 2;
    localparam int MARK_PAUSE      = 3;

    logic                    clk_28;
    logic                    reset;
    logic                    i_download;
    logic                    i_dl_wr;
    logic [`TAPE_ADDR_W-1:0] i_dl_addr;
    logic [`TAPE_BYTE_W-1:0] i_dl_data;
    logic                    i_byte_req;
    // Loop start, loop next, stop and pause button
    logic [3:0]              marks;
    logic                    o_byte_ack;
    logic [`TAPE_BYTE_W-1:0] o_byte_data;
    logic                    o_motor;

    logic [`TAPE_BYTE_W-1:0] image [0:IMG_LEN-1];
    integer                  seed;
    int                      errors = 0;
    int                      checks = 0;
    int                      acks;
    int                      model_addr;
    int                      loop_addr;

    tape_buffer_top dut_i (
        .clk_28       (clk_28),
        .reset        (reset),
        .i_download   (i_download),
        .i_dl_wr      (i_dl_wr),
        .i_dl_addr    (i_dl_addr),
        .i_dl_data    (i_dl_data),
        .i_byte_req   (i_byte_req),
        .i_loop_start (marks[MARK_LOOP_START]),
        .i_loop_next  (marks[MARK_LOOP_NEXT]),
        .i_stop       (marks[MARK_STOP]),
        .i_pause_btn  (marks[MARK_PAUSE]),
        .o_byte_ack   (o_byte_ack),
        .o_byte_data  (o_byte_data),
        .o_motor      (o_motor)
    );

    initial begin
        clk_28 = 1'b0;
        forever #50 clk_28 = ~clk_28;
    end

    // Expected tape byte at a play address
    function automatic logic [`TAPE_BYTE_W-1:0] ref_byte(input int addr);
        if (addr < IMG_LEN) begin
            return image[addr];
        end
        return '0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, exp);
        end
    endtask

    // ========================================================================
    // Reference model, follows the play address and compares every ack
    // ========================================================================
    initial begin : reference_tracker
        logic       ack_prev;
        logic [3:0] marks_prev;
        ack_prev   = 1'b0;
        marks_prev = '0;
        acks       = 0;
        model_addr = 0;
        loop_addr  = 0;
        forever begin
            @(negedge clk_28);
            if (reset || i_download) begin
                model_addr = 0;
                loop_addr  = 0;
            end else begin
                if (o_byte_ack != ack_prev) begin
                    check_value("o_byte_data", 32'(o_byte_data), 32'(ref_byte(model_addr)));
                    model_addr++;
                    acks++;
                end
                if (marks[MARK_LOOP_START] && !marks_prev[MARK_LOOP_START]) begin
                    loop_addr = model_addr;
                end
                if (marks[MARK_LOOP_NEXT] && !marks_prev[MARK_LOOP_NEXT]) begin
                    model_addr = loop_addr;
                end
            end
            ack_prev   = o_byte_ack;
            marks_prev = marks;
        end
    end

    task automatic download_image();
        int i;
        @(posedge clk_28);
        #5;
        i_download = 1'b1;
        for (i = 0; i < IMG_LEN; i++) begin
            @(posedge clk_28);
            #5;
            i_dl_wr   = 1'b1;
            i_dl_addr = i[`TAPE_ADDR_W-1:0];
            i_dl_data = image[i];
        end
        @(posedge clk_28);
        #5;
        i_dl_wr    = 1'b0;
        i_download = 1'b0;
        // Loading level and mode settle two cycles later
        repeat (3) @(posedge clk_28);
    endtask

    // Edge acts 2 cycles later, so the mark is held long enough to land
    task automatic pulse_mark(input int idx);
        @(posedge clk_28);
        #5;
        marks[idx] = 1'b1;
        repeat (2) @(posedge clk_28);
        #5;
        marks[idx] = 1'b0;
        repeat (2) @(posedge clk_28);
    endtask

    task automatic request_byte();
        int waited;
        @(posedge clk_28);
        #5;
        i_byte_req = ~i_byte_req;
        waited     = 0;
        while (o_byte_ack != i_byte_req && waited < ACK_TIMEOUT) begin
            @(negedge clk_28);
            waited++;
        end
        if (o_byte_ack != i_byte_req) begin
            errors++;
            $display("Timeout at %0t: byte request was never acknowledged", $time);
        end
    endtask

    task automatic play_bytes(input int count);
        repeat (count) request_byte();
    endtask

    task automatic wait_motor(input logic level);
        int waited;
        waited = 0;
        while (o_motor !== level && waited < MOTOR_TIMEOUT) begin
            @(negedge clk_28);
            waited++;
        end
        checks++;
        if (o_motor !== level) begin
            errors++;
            $display("Timeout at %0t: motor did not go to %0d", $time, level);
        end
    endtask

    // Request past the end of the tape must stay open
    task automatic expect_no_ack(input int cycles);
        int waited;
        waited = 0;
        checks++;
        while (waited < cycles) begin
            @(negedge clk_28);
            if (o_byte_ack == i_byte_req) begin
                errors++;
                $display("Request past the end of the tape was acknowledged at %0t", $time);
                waited = cycles;
            end
            waited++;
        end
    endtask

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin : stimulus
        int i;
        reset      = 1'b1;
        i_download = 1'b0;
        i_dl_wr    = 1'b0;
        i_dl_addr  = '0;
        i_dl_data  = '0;
        i_byte_req = 1'b0;
        marks      = '0;
        seed       = 32'h18e4;
        for (i = 0; i < IMG_LEN; i++) begin
            image[i] = 8'($random(seed));
        end
        repeat (3) @(posedge clk_28);
        #5;
        reset = 1'b0;

        check_value("o_byte_ack", 32'(o_byte_ack), 32'd0);
        check_value("o_motor", 32'(o_motor), 32'd0);
        download_image();
        check_value("o_motor", 32'(o_motor), 32'd0);

        // Start play, first bytes mix word fetches and reuse
        pulse_mark(MARK_PAUSE);
        wait_motor(1'b1);
        play_bytes(5);

        // Loop start at odd address 5, jump back from 9 forces a refetch
        pulse_mark(MARK_LOOP_START);
        play_bytes(4);
        pulse_mark(MARK_LOOP_NEXT);
        play_bytes(3);

        pulse_mark(MARK_STOP);
        wait_motor(1'b0);
        pulse_mark(MARK_PAUSE);
        wait_motor(1'b1);
        play_bytes(IMG_LEN - 8);

        @(posedge clk_28);
        #5;
        i_byte_req = ~i_byte_req;
        wait_motor(1'b0);
        expect_no_ack(ACK_TIMEOUT);

        check_value("ack_count", 32'(acks), 32'd28);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/tape_pkg.sv
logic/tape_event_decode.sv
logic/tape_position_ctrl.sv
logic/tape_word_ram.sv
logic/tape_byte_fetch.sv
logic/tape_buffer_top.sv
verification/tape_buffer_tb.sv

// ==== Makefile ====
# Verilator build and run of the tape byte server testbench

VERILATOR ?= verilator
TOP       ?= tape_buffer_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Test FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Test FAILED, no result"; exit 1; fi
	@echo "Test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
